// ==== hw/axi_cmd_sequencer.sv ====
/*
 Issues one held command at a time on AR or AW+W.
 Writes repeat the single request data word on every beat.
 An illegal class, funct or size code locks the FSM in FAULT until reset.
*/
module axi_cmd_sequencer (
	input logic rvx_port_19,
	input logic rvx_port_04,
	mem_cmd_if.runner slot,
	input logic is_read,
	input logic is_write,
	input logic is_illegal,
	input logic [mem_cmd_pkg::AXI_LEN_W-1:0] len,
	input logic [mem_cmd_pkg::AXI_SIZE_W-1:0] size,
	input logic [mem_cmd_pkg::AXI_BURST_W-1:0] burst,
	input logic size_bad,
	output logic ar_valid,
	input logic ar_ready,
	output logic [mem_cmd_pkg::ADDR_W-1:0] ar_addr,
	output logic [mem_cmd_pkg::AXI_LEN_W-1:0] ar_len,
	output logic [mem_cmd_pkg::AXI_SIZE_W-1:0] ar_size,
	output logic [mem_cmd_pkg::AXI_BURST_W-1:0] ar_burst,
	output logic aw_valid,
	input logic aw_ready,
	output logic [mem_cmd_pkg::ADDR_W-1:0] aw_addr,
	output logic [mem_cmd_pkg::AXI_LEN_W-1:0] aw_len,
	output logic [mem_cmd_pkg::AXI_SIZE_W-1:0] aw_size,
	output logic [mem_cmd_pkg::AXI_BURST_W-1:0] aw_burst,
	output logic w_valid,
	input logic w_ready,
	output logic [mem_cmd_pkg::DATA_W-1:0] w_data,
	output logic [mem_cmd_pkg::STRB_W-1:0] w_strb,
	output logic w_last,
	output logic done,
	output logic fault
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ_ADDR,
		ST_WRITE_ADDR,
		ST_WRITE_DATA,
		ST_FAULT
	} state_t;

	state_t state;
	logic go_read;
	logic go_write;
	logic go_fault;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] len_q;
	logic [mem_cmd_pkg::AXI_SIZE_W-1:0] size_q;
	logic [mem_cmd_pkg::AXI_BURST_W-1:0] burst_q;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] beats_left;

	// Either classifier can reject the command
	assign go_fault = (state == ST_IDLE) & slot.slot_valid & (is_illegal | size_bad);
	assign go_read = (state == ST_IDLE) & slot.slot_valid & is_read & ~size_bad;
	assign go_write = (state == ST_IDLE) & slot.slot_valid & is_write & ~size_bad;

	assign ar_hs = ar_valid & ar_ready;
	assign aw_hs = aw_valid & aw_ready;
	assign w_hs = w_valid & w_ready;

	// ****************************************
	// FSM
	// ****************************************
	always_ff @(posedge rvx_port_19 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (go_fault)
						state <= ST_FAULT;
					else if (go_read)
						state <= ST_READ_ADDR;
					else if (go_write)
						state <= ST_WRITE_ADDR;
				ST_READ_ADDR:
					if (ar_hs)
						state <= ST_IDLE;
				ST_WRITE_ADDR:
					if (aw_hs)
						state <= ST_WRITE_DATA;
				ST_WRITE_DATA:
					if (w_hs && w_last)
						state <= ST_IDLE;
				default:
					state <= ST_FAULT;
			endcase
		end
	end

	// Burst shape is frozen for the whole transaction
	always_ff @(posedge rvx_port_19)
	begin
		if (slot.start)
		begin
			len_q <= len;
			size_q <= size;
			burst_q <= burst;
		end
	end

	// Remaining W beats after the current one
	always_ff @(posedge rvx_port_19 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			beats_left <= '0;
		else if (go_write)
			beats_left <= len;
		else if (w_hs)
			beats_left <= beats_left - 1'b1;
	end

	// ****************************************
	// Channel outputs
	// ****************************************
	assign ar_valid = (state == ST_READ_ADDR);
	assign ar_addr = slot.cmd.addr;
	assign ar_len = len_q;
	assign ar_size = size_q;
	assign ar_burst = burst_q;

	assign aw_valid = (state == ST_WRITE_ADDR);
	assign aw_addr = slot.cmd.addr;
	assign aw_len = len_q;
	assign aw_size = size_q;
	assign aw_burst = burst_q;

	assign w_valid = (state == ST_WRITE_DATA);
	assign w_data = slot.cmd.wdata;
	assign w_strb = slot.cmd.wstrb;
	assign w_last = (beats_left == '0);

	assign slot.start = go_read | go_write;
	assign slot.finish = ar_hs | (w_hs & w_last);
	assign done = slot.finish;
	assign fault = (state == ST_FAULT);

endmodule

// ==== hw/burst_planner.sv ====
/*
 Maps the size code of the held command to AXI len, size and burst.
 Codes 0-2 are single beats, 3-6 are 4-byte INCR bursts, code 7 is flagged.
*/
module burst_planner (
	mem_cmd_if.viewer slot,
	output logic [mem_cmd_pkg::AXI_LEN_W-1:0] len,
	output logic [mem_cmd_pkg::AXI_SIZE_W-1:0] size,
	output logic [mem_cmd_pkg::AXI_BURST_W-1:0] burst,
	output logic size_bad
);

	always_comb
	begin
		len = '0;
		size = '0;
		burst = mem_cmd_pkg::BURST_FIXED;
		size_bad = 1'b0;
		case (slot.cmd.size_code)
			3'd0, 3'd1, 3'd2:
				// Single beat, size follows the code directly
				size = slot.cmd.size_code;
			3'd3, 3'd4, 3'd5, 3'd6:
			begin
				burst = mem_cmd_pkg::BURST_INCR;
				size = mem_cmd_pkg::AXI_SIZE_4B;
				case (slot.cmd.size_code)
					3'd3: len = mem_cmd_pkg::AXI_LEN_W'(1);
					3'd4: len = mem_cmd_pkg::AXI_LEN_W'(3);
					3'd5: len = mem_cmd_pkg::AXI_LEN_W'(7);
					default: len = mem_cmd_pkg::AXI_LEN_W'(15);
				endcase
			end
			default:
				size_bad = slot.slot_valid;
		endcase
	end

endmodule

// ==== hw/cmd_arbiter.sv ====
/*
 Two-requester round-robin arbiter with a single holding slot.
 A requester keeps req high with stable fields until its ack pulse.
 The slot frees on the cycle after finish.
*/
module cmd_arbiter (
	input logic rvx_port_19,
	input logic rvx_port_04,
	input logic req_a,
	input mem_cmd_pkg::mem_cmd_t cmd_a,
	input logic req_b,
	input mem_cmd_pkg::mem_cmd_t cmd_b,
	output logic ack_a,
	output logic ack_b,
	mem_cmd_if.holder slot
);

	logic last_b;
	logic pick_b;
	logic grant;

	// B wins when alone, or when both ask and A had the last grant
	assign pick_b = req_b & (~req_a | ~last_b);
	assign grant = ~slot.slot_valid & (req_a | req_b);

	always_ff @(posedge rvx_port_19 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			slot.slot_valid <= 1'b0;
			ack_a <= 1'b0;
			ack_b <= 1'b0;
			last_b <= 1'b0;
		end
		else
		begin
			ack_a <= 1'b0;
			ack_b <= 1'b0;
			if (grant)
			begin
				slot.slot_valid <= 1'b1;
				ack_a <= ~pick_b;
				ack_b <= pick_b;
				last_b <= pick_b;
			end
			else if (slot.finish)
				slot.slot_valid <= 1'b0;
		end
	end

	// Holding register, only meaningful while slot_valid is high
	always_ff @(posedge rvx_port_19)
	begin
		if (grant)
			slot.cmd <= pick_b ? cmd_b : cmd_a;
	end

endmodule

// ==== hw/cmd_decoder.sv ====
/*
 Sorts the held command into read, write or illegal.
 Outputs are one-hot while the slot is valid and all low otherwise.
*/
module cmd_decoder (
	mem_cmd_if.viewer slot,
	output logic is_read,
	output logic is_write,
	output logic is_illegal
);

	always_comb
	begin
		is_read = 1'b0;
		is_write = 1'b0;
		is_illegal = 1'b0;
		if (slot.slot_valid)
		begin
			case (slot.cmd.cls)
				mem_cmd_pkg::CLS_STD:
					case (slot.cmd.funct)
						3'd4, 3'd6: is_read = 1'b1;
						3'd0, 3'd1: is_write = 1'b1;
						default: is_illegal = 1'b1;
					endcase
				mem_cmd_pkg::CLS_EXT:
					case (slot.cmd.funct)
						3'd1: is_read = 1'b1;
						3'd0, 3'd7: is_write = 1'b1;
						default: is_illegal = 1'b1;
					endcase
				default: is_illegal = 1'b1;
			endcase
		end
	end

endmodule

// ==== hw/mem_cmd_axi_bridge.sv ====
/*
 Memory command bridge top with plain ports.
 One command in flight, AR/AW/W only, AXI IDs are implied constant.
*/
module mem_cmd_axi_bridge (
	input logic rvx_port_19,
	input logic rvx_port_04,
	input logic req_a,
	input logic [mem_cmd_pkg::CLS_W-1:0] cls_a,
	input logic [mem_cmd_pkg::FUNCT_W-1:0] funct_a,
	input logic [mem_cmd_pkg::SIZE_W-1:0] size_a,
	input logic [mem_cmd_pkg::ADDR_W-1:0] addr_a,
	input logic [mem_cmd_pkg::DATA_W-1:0] wdata_a,
	input logic [mem_cmd_pkg::STRB_W-1:0] wstrb_a,
	output logic ack_a,
	input logic req_b,
	input logic [mem_cmd_pkg::CLS_W-1:0] cls_b,
	input logic [mem_cmd_pkg::FUNCT_W-1:0] funct_b,
	input logic [mem_cmd_pkg::SIZE_W-1:0] size_b,
	input logic [mem_cmd_pkg::ADDR_W-1:0] addr_b,
	input logic [mem_cmd_pkg::DATA_W-1:0] wdata_b,
	input logic [mem_cmd_pkg::STRB_W-1:0] wstrb_b,
	output logic ack_b,
	output logic ar_valid,
	input logic ar_ready,
	output logic [mem_cmd_pkg::ADDR_W-1:0] ar_addr,
	output logic [mem_cmd_pkg::AXI_LEN_W-1:0] ar_len,
	output logic [mem_cmd_pkg::AXI_SIZE_W-1:0] ar_size,
	output logic [mem_cmd_pkg::AXI_BURST_W-1:0] ar_burst,
	output logic aw_valid,
	input logic aw_ready,
	output logic [mem_cmd_pkg::ADDR_W-1:0] aw_addr,
	output logic [mem_cmd_pkg::AXI_LEN_W-1:0] aw_len,
	output logic [mem_cmd_pkg::AXI_SIZE_W-1:0] aw_size,
	output logic [mem_cmd_pkg::AXI_BURST_W-1:0] aw_burst,
	output logic w_valid,
	input logic w_ready,
	output logic [mem_cmd_pkg::DATA_W-1:0] w_data,
	output logic [mem_cmd_pkg::STRB_W-1:0] w_strb,
	output logic w_last,
	output logic done,
	output logic fault
);

	mem_cmd_pkg::mem_cmd_t cmd_a;
	mem_cmd_pkg::mem_cmd_t cmd_b;
	logic is_read;
	logic is_write;
	logic is_illegal;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] len;
	logic [mem_cmd_pkg::AXI_SIZE_W-1:0] size;
	logic [mem_cmd_pkg::AXI_BURST_W-1:0] burst;
	logic size_bad;

	// Requester fields packed in struct order
	assign cmd_a = '{cls: cls_a, funct: funct_a, size_code: size_a,
		addr: addr_a, wdata: wdata_a, wstrb: wstrb_a};
	assign cmd_b = '{cls: cls_b, funct: funct_b, size_code: size_b,
		addr: addr_b, wdata: wdata_b, wstrb: wstrb_b};

	mem_cmd_if slot_if ();

	cmd_arbiter cmd_arbiter_inst (
		.rvx_port_19(rvx_port_19),
		.rvx_port_04(rvx_port_04),
		.req_a(req_a),
		.cmd_a(cmd_a),
		.req_b(req_b),
		.cmd_b(cmd_b),
		.ack_a(ack_a),
		.ack_b(ack_b),
		.slot(slot_if.holder)
	);

	// Decoder and planner look at the same held command in parallel
	cmd_decoder cmd_decoder_inst (
		.slot(slot_if.viewer),
		.is_read(is_read),
		.is_write(is_write),
		.is_illegal(is_illegal)
	);

	burst_planner burst_planner_inst (
		.slot(slot_if.viewer),
		.len(len),
		.size(size),
		.burst(burst),
		.size_bad(size_bad)
	);

	axi_cmd_sequencer axi_cmd_sequencer_inst (
		.rvx_port_19(rvx_port_19),
		.rvx_port_04(rvx_port_04),
		.slot(slot_if.runner),
		.is_read(is_read),
		.is_write(is_write),
		.is_illegal(is_illegal),
		.len(len),
		.size(size),
		.burst(burst),
		.size_bad(size_bad),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar_addr(ar_addr),
		.ar_len(ar_len),
		.ar_size(ar_size),
		.ar_burst(ar_burst),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw_addr(aw_addr),
		.aw_len(aw_len),
		.aw_size(aw_size),
		.aw_burst(aw_burst),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w_data(w_data),
		.w_strb(w_strb),
		.w_last(w_last),
		.done(done),
		.fault(fault)
	);

endmodule

// ==== hw/mem_cmd_if.sv ====
/*
 Held command slot between the arbiter and the command path.
 start and finish are one-cycle pulses from the sequencer.
*/
interface mem_cmd_if;

	logic slot_valid;
	mem_cmd_pkg::mem_cmd_t cmd;
	logic start;
	logic finish;

	// Arbiter side owns the holding slot
	modport holder (output slot_valid, output cmd, input start, input finish);

	// Decoder and planner only look at the held command
	modport viewer (input slot_valid, input cmd);

	modport runner (input slot_valid, input cmd, output start, output finish);

endinterface

// ==== hw/mem_cmd_pkg.sv ====
/*
 Shared widths, codes and the request struct of the memory command bridge.
 The AXI fields cover only what the bridge drives: no IDs, no response channels.
*/
package mem_cmd_pkg;

	// ****************************************
	// Data path widths
	// ****************************************
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// ****************************************
	// Command fields
	// ****************************************
	localparam int CLS_W = 2;
	localparam int FUNCT_W = 3;
	localparam int SIZE_W = 3;

	// Legal classes, every other class code is illegal
	localparam logic [CLS_W-1:0] CLS_STD = 2'd0;
	localparam logic [CLS_W-1:0] CLS_EXT = 2'd1;

	// ****************************************
	// AXI encodings
	// ****************************************
	localparam int AXI_LEN_W = 8;
	localparam int AXI_SIZE_W = 3;
	localparam int AXI_BURST_W = 2;

	localparam logic [AXI_BURST_W-1:0] BURST_FIXED = 2'b00;
	localparam logic [AXI_BURST_W-1:0] BURST_INCR = 2'b01;
	localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_4B = 3'd2;

	typedef struct packed {
		logic [CLS_W-1:0] cls;
		logic [FUNCT_W-1:0] funct;
		logic [SIZE_W-1:0] size_code;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
	} mem_cmd_t;

endpackage

// ==== project.f ====
hw/mem_cmd_pkg.sv
hw/mem_cmd_if.sv
hw/cmd_arbiter.sv
hw/cmd_decoder.sv
hw/burst_planner.sv
hw/axi_cmd_sequencer.sv
hw/mem_cmd_axi_bridge.sv
verif/bridge_properties.sv
verif/tb_mem_cmd_axi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module tb_mem_cmd_axi_bridge -o sim_bridge
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_bridge +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "STATUS: PASS"; then
	exit 0
fi
exit 1

// ==== verif/bridge_properties.sv ====
/*
 Concurrent checks bound into mem_cmd_axi_bridge, with their own decode and size tables.
 The command under test is taken from the requester fields during its ack pulse.
 fail_count holds the number of failed assertions.
*/
module bridge_properties (
	input logic rvx_port_19,
	input logic rvx_port_04,
	input logic req_a,
	input logic req_b,
	input logic ack_a,
	input logic ack_b,
	input mem_cmd_pkg::mem_cmd_t cmd_a,
	input mem_cmd_pkg::mem_cmd_t cmd_b,
	input logic ar_valid,
	input logic ar_ready,
	input logic [mem_cmd_pkg::ADDR_W-1:0] ar_addr,
	input logic [mem_cmd_pkg::AXI_LEN_W-1:0] ar_len,
	input logic [mem_cmd_pkg::AXI_SIZE_W-1:0] ar_size,
	input logic [mem_cmd_pkg::AXI_BURST_W-1:0] ar_burst,
	input logic aw_valid,
	input logic aw_ready,
	input logic [mem_cmd_pkg::ADDR_W-1:0] aw_addr,
	input logic [mem_cmd_pkg::AXI_LEN_W-1:0] aw_len,
	input logic [mem_cmd_pkg::AXI_SIZE_W-1:0] aw_size,
	input logic [mem_cmd_pkg::AXI_BURST_W-1:0] aw_burst,
	input logic w_valid,
	input logic w_ready,
	input logic [mem_cmd_pkg::DATA_W-1:0] w_data,
	input logic [mem_cmd_pkg::STRB_W-1:0] w_strb,
	input logic w_last,
	input logic done,
	input logic fault
);
	timeunit 1ns;
	timeprecision 1ps;

	mem_cmd_pkg::mem_cmd_t held;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] beat;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] exp_len;
	logic [mem_cmd_pkg::AXI_SIZE_W-1:0] exp_size;
	logic [mem_cmd_pkg::AXI_BURST_W-1:0] exp_burst;
	logic [44:0] exp_shape;
	logic [44:0] ar_shape;
	logic [44:0] aw_shape;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic last_b;
	logic acked;
	logic acked_bad;
	int fail_count;

	// ****************************************
	// Decode and size tables
	// ****************************************
	function automatic logic cmd_read(mem_cmd_pkg::mem_cmd_t c);
		if (c.cls == mem_cmd_pkg::CLS_STD)
			return (c.funct == 3'd4) || (c.funct == 3'd6);
		return (c.cls == mem_cmd_pkg::CLS_EXT) && (c.funct == 3'd1);
	endfunction

	function automatic logic cmd_write(mem_cmd_pkg::mem_cmd_t c);
		if (c.cls == mem_cmd_pkg::CLS_STD)
			return (c.funct == 3'd0) || (c.funct == 3'd1);
		return (c.cls == mem_cmd_pkg::CLS_EXT) && ((c.funct == 3'd0) || (c.funct == 3'd7));
	endfunction

	function automatic logic cmd_bad(mem_cmd_pkg::mem_cmd_t c);
		return !(cmd_read(c) || cmd_write(c)) || (c.size_code == 3'd7);
	endfunction

	function automatic void count_fail(string msg);
		fail_count++;
		$error("%s", msg);
	endfunction

	// Codes 3 to 6 are 2, 4, 8 and 16 beats of 4 bytes
	assign exp_len = (held.size_code < 3'd3) ? '0 :
		mem_cmd_pkg::AXI_LEN_W'((1 << (held.size_code - 3'd2)) - 1);
	assign exp_size = (held.size_code < 3'd3) ? held.size_code : 3'd2;
	assign exp_burst = (held.size_code < 3'd3) ? mem_cmd_pkg::BURST_FIXED : mem_cmd_pkg::BURST_INCR;
	assign exp_shape = {held.addr, exp_len, exp_size, exp_burst};
	assign ar_shape = {ar_addr, ar_len, ar_size, ar_burst};
	assign aw_shape = {aw_addr, aw_len, aw_size, aw_burst};
	assign ar_hs = ar_valid & ar_ready;
	assign aw_hs = aw_valid & aw_ready;
	assign w_hs = w_valid & w_ready;
	assign acked_bad = ack_b ? cmd_bad(cmd_b) : cmd_bad(cmd_a);

	// Requester still holds its fields while ack is high
	always_ff @(posedge rvx_port_19)
	begin
		if (ack_a || ack_b)
			held <= ack_b ? cmd_b : cmd_a;
	end

	always_ff @(posedge rvx_port_19 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			beat <= '0;
			last_b <= 1'b0;
			acked <= 1'b0;
		end
		else
		begin
			if (ack_a || ack_b)
			begin
				last_b <= ack_b;
				acked <= 1'b1;
			end
			if (aw_hs)
				beat <= '0;
			else if (w_hs)
				beat <= beat + 8'd1;
		end
	end

	// ****************************************
	// Channel checks
	// ****************************************
	ar_fields: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		ar_hs |-> cmd_read(held) && ar_shape == exp_shape)
		else count_fail($sformatf("Error at %0t: ar_addr/len/size/burst %h, expected %h",
			$time, ar_shape, exp_shape));
	aw_fields: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		aw_hs |-> cmd_write(held) && aw_shape == exp_shape)
		else count_fail($sformatf("Error at %0t: aw_addr/len/size/burst %h, expected %h",
			$time, aw_shape, exp_shape));
	w_payload: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		w_hs |-> {w_data, w_strb} == {held.wdata, held.wstrb})
		else count_fail($sformatf("Error at %0t: w_data/w_strb %h, expected %h",
			$time, {w_data, w_strb}, {held.wdata, held.wstrb}));
	w_last_beat: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		w_hs |-> w_last == (beat == exp_len))
		else count_fail($sformatf("Error at %0t: w_last %b, expected %b",
			$time, w_last, beat == exp_len));
	// Done follows the AR handshake or the counted final W beat
	done_pulse: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		done == (ar_hs || (w_hs && beat == exp_len)))
		else count_fail($sformatf("Error at %0t: done %b, expected %b",
			$time, done, ar_hs || (w_hs && beat == exp_len)));
	one_per_cmd: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		done |=> !ar_valid && !aw_valid && !w_valid)
		else count_fail("A valid was still raised in the cycle after done");

	// Back-pressure keeps each valid and its fields
	ar_hold: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_shape))
		else count_fail("AR valid dropped or its fields changed before ar_ready");
	aw_hold: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_shape))
		else count_fail("AW valid dropped or its fields changed before aw_ready");
	w_hold: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		w_valid && !w_ready |=> w_valid && $stable({w_data, w_strb, w_last}))
		else count_fail("W valid dropped or its fields changed before w_ready");

	// ****************************************
	// Arbitration, fault and reset
	// ****************************************
	ack_order: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		(ack_a || ack_b) |-> !(ack_a && ack_b) &&
			(!acked || !$past(req_a && req_b) || (ack_b != last_b)))
		else count_fail("Both acks pulsed, or a tie was not granted round-robin");
	fault_entry: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		(ack_a || ack_b) |=> fault == $past(acked_bad))
		else count_fail($sformatf("Error at %0t: fault %b, expected %b",
			$time, fault, $past(acked_bad)));
	fault_lock: assert property (@(posedge rvx_port_19) disable iff (!rvx_port_04)
		fault |=> fault && !ar_valid && !aw_valid && !w_valid)
		else count_fail("Fault cleared or a valid rose while in fault");
	reset_quiet: assert property (@(posedge rvx_port_19)
		$rose(rvx_port_04) |-> !(ar_valid || aw_valid || w_valid || ack_a || ack_b ||
			done || fault))
		else count_fail("An output was high right after reset was released");

endmodule

bind mem_cmd_axi_bridge bridge_properties props_inst (.*);

// ==== verif/tb_mem_cmd_axi_bridge.sv ====
/*
 Testbench for mem_cmd_axi_bridge. Random legal commands come first one at a time,
 then from both requesters at once, and an illegal command runs last.
 Checking sits in the bound bridge_properties assertions; ready lines stall at random.
*/
module tb_mem_cmd_axi_bridge;
	timeunit 1ns;
	timeprecision 1ps;

	// 40 commands of at most 16 W beats, plus AW and random ready stalls
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int SEQ_CMDS = 24;
	localparam int PAIR_CMDS = 8;

	logic rvx_port_19;
	logic rvx_port_04;
	logic req_a;
	logic [mem_cmd_pkg::CLS_W-1:0] cls_a;
	logic [mem_cmd_pkg::FUNCT_W-1:0] funct_a;
	logic [mem_cmd_pkg::SIZE_W-1:0] size_a;
	logic [mem_cmd_pkg::ADDR_W-1:0] addr_a;
	logic [mem_cmd_pkg::DATA_W-1:0] wdata_a;
	logic [mem_cmd_pkg::STRB_W-1:0] wstrb_a;
	logic ack_a;
	logic req_b;
	logic [mem_cmd_pkg::CLS_W-1:0] cls_b;
	logic [mem_cmd_pkg::FUNCT_W-1:0] funct_b;
	logic [mem_cmd_pkg::SIZE_W-1:0] size_b;
	logic [mem_cmd_pkg::ADDR_W-1:0] addr_b;
	logic [mem_cmd_pkg::DATA_W-1:0] wdata_b;
	logic [mem_cmd_pkg::STRB_W-1:0] wstrb_b;
	logic ack_b;
	logic ar_valid;
	logic ar_ready;
	logic [mem_cmd_pkg::ADDR_W-1:0] ar_addr;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] ar_len;
	logic [mem_cmd_pkg::AXI_SIZE_W-1:0] ar_size;
	logic [mem_cmd_pkg::AXI_BURST_W-1:0] ar_burst;
	logic aw_valid;
	logic aw_ready;
	logic [mem_cmd_pkg::ADDR_W-1:0] aw_addr;
	logic [mem_cmd_pkg::AXI_LEN_W-1:0] aw_len;
	logic [mem_cmd_pkg::AXI_SIZE_W-1:0] aw_size;
	logic [mem_cmd_pkg::AXI_BURST_W-1:0] aw_burst;
	logic w_valid;
	logic w_ready;
	logic [mem_cmd_pkg::DATA_W-1:0] w_data;
	logic [mem_cmd_pkg::STRB_W-1:0] w_strb;
	logic w_last;
	logic done;
	logic fault;
	int cycles;
	int timeouts;

	mem_cmd_axi_bridge mem_cmd_axi_bridge_inst (.*);

	always #4 rvx_port_19 = ~rvx_port_19;

	// AXI slave model, ready low about a quarter of the time
	always @(posedge rvx_port_19)
	begin
		ar_ready <= ($urandom_range(3) != 0);
		aw_ready <= ($urandom_range(3) != 0);
		w_ready <= ($urandom_range(3) != 0);
	end

	// ****************************************
	// Requester tasks
	// ****************************************
	task automatic pick_legal_cmd(output logic [mem_cmd_pkg::CLS_W-1:0] cls,
			output logic [mem_cmd_pkg::FUNCT_W-1:0] funct,
			output logic [mem_cmd_pkg::SIZE_W-1:0] size);
		logic wr;
		wr = ($urandom_range(1) != 0);
		cls = $urandom_range(1) ? mem_cmd_pkg::CLS_EXT : mem_cmd_pkg::CLS_STD;
		if (cls == mem_cmd_pkg::CLS_STD)
			funct = wr ? 3'($urandom_range(1)) : ($urandom_range(1) ? 3'd6 : 3'd4);
		else
			funct = wr ? ($urandom_range(1) ? 3'd7 : 3'd0) : 3'd1;
		size = 3'($urandom_range(6));
	endtask

	// Called right after a rising edge
	task automatic drive_req(input bit use_b, input logic [mem_cmd_pkg::CLS_W-1:0] cls,
			input logic [mem_cmd_pkg::FUNCT_W-1:0] funct,
			input logic [mem_cmd_pkg::SIZE_W-1:0] size);
		if (use_b)
		begin
			req_b <= 1'b1;
			cls_b <= cls;
			funct_b <= funct;
			size_b <= size;
			addr_b <= $urandom;
			wdata_b <= $urandom;
			wstrb_b <= mem_cmd_pkg::STRB_W'($urandom);
		end
		else
		begin
			req_a <= 1'b1;
			cls_a <= cls;
			funct_a <= funct;
			size_a <= size;
			addr_a <= $urandom;
			wdata_a <= $urandom;
			wstrb_a <= mem_cmd_pkg::STRB_W'($urandom);
		end
	endtask

	task automatic wait_ack(input bit use_b);
		do
			@(posedge rvx_port_19);
		while (use_b ? !ack_b : !ack_a);
		// Req drops in the cycle after the ack
		if (use_b)
			req_b <= 1'b0;
		else
			req_a <= 1'b0;
	endtask

	task automatic wait_done();
		do
			@(posedge rvx_port_19);
		while (!done);
	endtask

	task automatic run_requester(input bit use_b, input int count);
		logic [mem_cmd_pkg::CLS_W-1:0] cls;
		logic [mem_cmd_pkg::FUNCT_W-1:0] funct;
		logic [mem_cmd_pkg::SIZE_W-1:0] size;
		for (int i = 0; i < count; i++)
		begin
			pick_legal_cmd(cls, funct, size);
			drive_req(use_b, cls, funct, size);
			wait_ack(use_b);
			wait_done();
		end
	endtask

	task automatic print_counts();
		$display("Run ended with %0d assertion failures and %0d timeouts",
			mem_cmd_axi_bridge_inst.props_inst.fail_count, timeouts);
	endtask

	// ****************************************
	// Main sequence
	// ****************************************
	initial
	begin
		logic [mem_cmd_pkg::CLS_W-1:0] cls;
		logic [mem_cmd_pkg::FUNCT_W-1:0] funct;
		logic [mem_cmd_pkg::SIZE_W-1:0] size;
		int kind;
		void'($urandom(16));
		rvx_port_19 = 1'b0;
		rvx_port_04 = 1'b0;
		req_a = 1'b0;
		cls_a = '0;
		funct_a = '0;
		size_a = '0;
		addr_a = '0;
		wdata_a = '0;
		wstrb_a = '0;
		req_b = 1'b0;
		cls_b = '0;
		funct_b = '0;
		size_b = '0;
		addr_b = '0;
		wdata_b = '0;
		wstrb_b = '0;
		ar_ready = 1'b0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		repeat (5) @(posedge rvx_port_19);
		rvx_port_04 <= 1'b1;
		@(posedge rvx_port_19);

		// One requester at a time, alternating
		for (int i = 0; i < SEQ_CMDS; i++)
			run_requester((i % 2) == 1, 1);

		// Both hold req together so ties must alternate
		fork
			run_requester(1'b0, PAIR_CMDS);
			run_requester(1'b1, PAIR_CMDS);
		join

		// Illegal class, funct or size code
		kind = $urandom_range(2);
		cls = (kind == 0) ? 2'd2 + 2'($urandom_range(1)) : mem_cmd_pkg::CLS_STD;
		funct = (kind == 1) ? 3'd5 : 3'd4;
		size = (kind == 2) ? 3'd7 : 3'd0;
		drive_req(1'b0, cls, funct, size);
		wait_ack(1'b0);

		// A legal request after the fault must stay unserved
		drive_req(1'b1, mem_cmd_pkg::CLS_STD, 3'd4, 3'd0);
		repeat (20) @(posedge rvx_port_19);
		req_b <= 1'b0;
		repeat (4) @(posedge rvx_port_19);

		print_counts();
		if (mem_cmd_axi_bridge_inst.props_inst.fail_count == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		cycles = 0;
		timeouts = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge rvx_port_19);
			cycles = cycles + 1;
		end
		timeouts = timeouts + 1;
		$display("Timeout after %0d cycles, the bridge stopped answering", cycles);
		print_counts();
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
